// ==== build.f ====
src/nx_pkg.sv
src/nx_ram.sv
src/nx_node_decoder.sv
src/nx_node_responder.sv
src/nx_stream_arbiter.sv
src/nx_node_distributor.sv
src/nx_node.sv
dv/nx_node_properties.sv
dv/nx_node_tb.sv

// ==== dv/nx_node_properties.sv ====
// Handshake and routing assertions for the mesh node, with their bind
`timescale 1ns/1ps
`default_nettype none

module nx_node_properties (
      input  logic                  i_clk
    , input  logic                  i_rst_n
    , input  nx_pkg::node_id_t      i_node_id
    , input  nx_pkg::nx_msg_t [3:0] i_inbound_data
    , input  logic [3:0]            i_inbound_valid
    , input  logic [3:0]            o_inbound_ready
    , input  nx_pkg::nx_msg_t [3:0] o_outbound_data
    , input  logic [3:0]            o_outbound_valid
    , input  logic [3:0]            i_outbound_ready
);

import nx_pkg::*;

// ================================================
// Per-port handshake
// ================================================

for (genvar g = 0; g < 4; g++) begin : g_port
    // Sender side of the inbound link
    a_in_stable: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_inbound_valid[g] && !o_inbound_ready[g]
        |=> i_inbound_valid[g] && $stable(i_inbound_data[g]))
        else $error("inbound port %0d changed a message before its transfer", g);

    a_out_stable: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_outbound_valid[g] && !i_outbound_ready[g]
        |=> o_outbound_valid[g] && $stable(o_outbound_data[g]))
        else $error("outbound port %0d changed a message before its transfer", g);

    // Local traffic never leaves
    a_not_local: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_outbound_valid[g] |-> (o_outbound_data[g].tgt != i_node_id))
        else $error("outbound port %0d carries a message for this node", g);
end

a_one_port: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    $onehot0(o_outbound_valid))
    else $error("more than one outbound valid is high");

endmodule : nx_node_properties

bind nx_node nx_node_properties u_properties (
      .i_clk            ( i_clk            )
    , .i_rst_n          ( i_rst_n          )
    , .i_node_id        ( i_node_id        )
    , .i_inbound_data   ( i_inbound_data   )
    , .i_inbound_valid  ( i_inbound_valid  )
    , .o_inbound_ready  ( o_inbound_ready  )
    , .o_outbound_data  ( o_outbound_data  )
    , .o_outbound_valid ( o_outbound_valid )
    , .i_outbound_ready ( i_outbound_ready )
);

`default_nettype wire

// ==== dv/nx_node_tb.sv ====
// Mesh node testbench: clock, reset, watchdog, routing model, directed tests, scoreboard
`timescale 1ns/1ps
`default_nettype none

module nx_node_tb;

import nx_pkg::*;

// ================================================
// Constants and signals
// ================================================

localparam int     CLK_PERIOD   = 4;
localparam int     RESET_CYCLES = 4;
localparam int     SEED         = 9036;
// Message count over all tests, and cycles allowed for each
localparam int     N_MSGS       = 90;
localparam int     MSG_CYCLES   = 40;
localparam int     DRAIN_CYCLES = 300;
localparam coord_t OWN_ROW      = 4'd2;
localparam coord_t OWN_COL      = 4'd2;
localparam node_id_t OWN_ID     = {OWN_ROW, OWN_COL};

logic          clk;
logic          rst_n;
logic          idle_in;
logic          idle_out;
nx_msg_t [3:0] in_data;
logic [3:0]    in_valid;
logic [3:0]    in_ready;
nx_msg_t [3:0] out_data;
logic [3:0]    out_valid;
logic [3:0]    out_ready = 4'hF;
logic [3:0]    present;

int   seed;
int   stall_seed;
int   checks;
int   errors;
int   stall_left;
logic bp_enable;
logic stall_seen;

// Scoreboard, expected and observed outbound transfers
nx_msg_t    exp_msg [$];
logic [1:0] exp_port [$];
nx_msg_t    obs_msg [$];
logic [1:0] obs_port [$];

nx_node #(
    .RAM_ADDR_W ( 8 )
) DUT (
      .i_clk              ( clk       )
    , .i_rst_n            ( rst_n     )
    , .i_node_id          ( OWN_ID    )
    , .i_idle             ( idle_in   )
    , .o_idle             ( idle_out  )
    , .i_inbound_data     ( in_data   )
    , .i_inbound_valid    ( in_valid  )
    , .o_inbound_ready    ( in_ready  )
    , .o_outbound_data    ( out_data  )
    , .o_outbound_valid   ( out_valid )
    , .i_outbound_ready   ( out_ready )
    , .i_outbound_present ( present   )
);

initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
end

initial begin
    #(N_MSGS * MSG_CYCLES * CLK_PERIOD);
    $display("Watchdog expired, the tests did not finish in time");
    $display("** FAIL **");
    $finish;
end

// Random stalls on every outbound port while back-pressure is on
always @(negedge clk) begin
    if (!bp_enable) begin
        out_ready = 4'hF;
    end else if (stall_left > 0) begin
        stall_left = stall_left - 1;
    end else begin
        stall_left = $random(stall_seed) & 7;
        out_ready  = ($random(stall_seed) & 1) ? 4'hF : 4'h0;
    end
end

// Record every outbound transfer
always @(posedge clk) begin
    for (int p = 0; p < 4; p++) begin
        if (out_valid[p] && out_ready[p]) begin
            obs_port.push_back(2'(p));
            obs_msg.push_back(out_data[p]);
        end
    end
end

// ================================================
// Helpers
// ================================================

task automatic check_val(input string name, input logic [63:0] exp_v, input logic [63:0] got_v);
    checks++;
    if (exp_v !== got_v) begin
        errors++;
        $display("CHECK FAILED %s expected 0x%0h got 0x%0h", name, exp_v, got_v);
    end
endtask

function automatic node_id_t mk_id(input int row, input int col);
    node_id_t id;
    id.row = 4'(row);
    id.col = 4'(col);
    return id;
endfunction

function automatic nx_msg_t make_msg(input node_id_t tgt, input node_id_t src,
                                     input cmd_t cmd, input addr_t addr, input data_t data);
    nx_msg_t m;
    m.tgt  = tgt;
    m.src  = src;
    m.cmd  = cmd;
    m.addr = addr;
    m.data = data;
    return m;
endfunction

// Column first, then row, then clockwise past missing neighbours
function automatic logic [1:0] ref_route(input node_id_t tgt, input logic [3:0] avail);
    logic [1:0] pref;
    logic [1:0] d;
    if (tgt.col != OWN_COL) begin
        pref = (tgt.col > OWN_COL) ? DIR_EAST : DIR_WEST;
    end else begin
        pref = (tgt.row > OWN_ROW) ? DIR_SOUTH : DIR_NORTH;
    end
    d = pref;
    repeat (4) begin
        if (avail[d]) begin
            return d;
        end
        d = d + 2'd1;
    end
    return pref;
endfunction

function automatic nx_msg_t rand_msg();
    logic [31:0] rnd;
    node_id_t    tgt;
    tgt = OWN_ID;
    while (tgt == OWN_ID) begin
        rnd = $random(seed);
        tgt = rnd[7:0];
    end
    rnd = $random(seed);
    return make_msg(tgt, rnd[15:8], (rnd[1:0] == 2'd3) ? CMD_WRITE : rnd[1:0],
                    rnd[31:24], $random(seed));
endfunction

function automatic node_id_t quad_target(input int k);
    case (k)
        0:       return mk_id(0, 2);
        1:       return mk_id(0, 5);
        2:       return mk_id(2, 5);
        3:       return mk_id(7, 6);
        4:       return mk_id(9, 2);
        5:       return mk_id(6, 0);
        6:       return mk_id(2, 1);
        default: return mk_id(1, 0);
    endcase
endfunction

function automatic node_id_t dir_target(input int d);
    case (d)
        0:       return mk_id(0, 2);
        1:       return mk_id(2, 9);
        2:       return mk_id(12, 2);
        default: return mk_id(2, 0);
    endcase
endfunction

task automatic expect_out(input nx_msg_t m, input logic [1:0] port);
    exp_msg.push_back(m);
    exp_port.push_back(port);
endtask

// Called just after a falling edge, returns once every masked port has transferred
task automatic send_batch(input nx_msg_t [3:0] msgs, input logic [3:0] mask);
    logic [3:0] pend;
    pend     = mask;
    in_data  = msgs;
    in_valid = pend;
    while (pend != 4'd0) begin
        @(posedge clk);
        if ((pend & ~in_ready) != 4'd0) begin
            stall_seen = 1'b1;
        end
        pend = pend & ~in_ready;
        @(negedge clk);
        in_valid = pend;
    end
endtask

task automatic send_one(input nx_msg_t m, input int port);
    nx_msg_t [3:0] msgs;
    msgs       = '0;
    msgs[port] = m;
    send_batch(msgs, 4'(1 << port));
endtask

task automatic wait_drain();
    int cyc;
    cyc = 0;
    while (!(idle_out && obs_msg.size() >= exp_msg.size()) && cyc < DRAIN_CYCLES) begin
        @(negedge clk);
        cyc++;
    end
    if (!(idle_out && obs_msg.size() >= exp_msg.size())) begin
        errors++;
        $display("Node did not drain within %0d cycles", DRAIN_CYCLES);
    end
endtask

// Single-path tests keep global order
task automatic check_ordered();
    int n;
    check_val("outbound message count", 64'(exp_msg.size()), 64'(obs_msg.size()));
    n = (exp_msg.size() < obs_msg.size()) ? exp_msg.size() : obs_msg.size();
    for (int i = 0; i < n; i++) begin
        check_val("outbound port", 64'(exp_port[i]), 64'(obs_port[i]));
        check_val($sformatf("o_outbound_data[%0d]", obs_port[i]), 64'(exp_msg[i]),
                  64'(obs_msg[i]));
    end
    exp_msg.delete();
    exp_port.delete();
    obs_msg.delete();
    obs_port.delete();
endtask

task automatic check_unordered();
    int hit;
    for (int i = 0; i < exp_msg.size(); i++) begin
        hit = -1;
        for (int j = 0; j < obs_msg.size(); j++) begin
            if (hit < 0 && obs_msg[j] == exp_msg[i] && obs_port[j] == exp_port[i]) begin
                hit = j;
            end
        end
        checks++;
        if (hit < 0) begin
            errors++;
            $display("Message 0x%0h never left the node on port %0d", exp_msg[i], exp_port[i]);
        end else begin
            obs_msg.delete(hit);
            obs_port.delete(hit);
        end
    end
    // Anything left over is a duplicate or a misroute
    foreach (obs_msg[j]) begin
        errors++;
        $display("Unexpected message 0x%0h left on port %0d", obs_msg[j], obs_port[j]);
    end
    exp_msg.delete();
    exp_port.delete();
    obs_msg.delete();
    obs_port.delete();
endtask

// ================================================
// Directed tests
// ================================================

task automatic test_reset();
    check_val("o_outbound_valid", 64'(4'h0), 64'(out_valid));
    check_val("o_inbound_ready", 64'(4'hF), 64'(in_ready));
    check_val("o_idle", 64'(1'b1), 64'(idle_out));
    idle_in = 1'b0;
    @(posedge clk);
    check_val("o_idle", 64'(1'b0), 64'(idle_out));
    @(negedge clk);
    idle_in = 1'b1;
    @(posedge clk);
    check_val("o_idle", 64'(1'b1), 64'(idle_out));
    @(negedge clk);
endtask

// Every quadrant from every inbound port
task automatic test_bypass();
    nx_msg_t m;
    for (int p = 0; p < 4; p++) begin
        for (int k = 0; k < 8; k++) begin
            m = make_msg(quad_target(k), mk_id(5, 5), CMD_WRITE, 8'(k), $random(seed));
            expect_out(m, ref_route(m.tgt, present));
            send_one(m, p);
        end
    end
    wait_drain();
    check_ordered();
endtask

task automatic test_write_read();
    addr_t       addrs [4];
    data_t       words [4];
    logic [31:0] rnd;
    node_id_t    reader;
    reader = mk_id(2, 0);
    for (int k = 0; k < 4; k++) begin
        rnd      = $random(seed);
        addrs[k] = {2'(k), rnd[5:0]};
        words[k] = $random(seed);
        send_one(make_msg(OWN_ID, reader, CMD_WRITE, addrs[k], words[k]), k);
    end
    for (int k = 0; k < 4; k++) begin
        expect_out(make_msg(reader, OWN_ID, CMD_RESPONSE, addrs[k], words[k]), DIR_WEST);
        send_one(make_msg(OWN_ID, reader, CMD_READ, addrs[k], $random(seed)), 3 - k);
    end
    // Overwrite followed at once by a read of the same word
    words[0] = $random(seed);
    send_one(make_msg(OWN_ID, reader, CMD_WRITE, addrs[0], words[0]), 0);
    expect_out(make_msg(reader, OWN_ID, CMD_RESPONSE, addrs[0], words[0]), DIR_WEST);
    send_one(make_msg(OWN_ID, reader, CMD_READ, addrs[0], 32'd0), 1);
    // A RESPONSE for this node has no consumer
    send_one(make_msg(OWN_ID, reader, CMD_RESPONSE, addrs[1], 32'hdead_beef), 2);
    wait_drain();
    check_ordered();
endtask

task automatic test_absent();
    nx_msg_t m;
    for (int d = 0; d < 4; d++) begin
        present = 4'hF & ~4'(1 << d);
        m = make_msg(dir_target(d), mk_id(5, 5), CMD_WRITE, 8'(d), $random(seed));
        expect_out(m, ref_route(m.tgt, present));
        send_one(m, d);
        wait_drain();
    end
    // Only the west neighbour left
    present = 4'b1000;
    m = make_msg(dir_target(0), mk_id(5, 5), CMD_READ, 8'h40, $random(seed));
    expect_out(m, ref_route(m.tgt, present));
    send_one(m, 2);
    wait_drain();
    present = 4'hF;
    check_ordered();
endtask

task automatic test_backpressure();
    nx_msg_t m;
    stall_seen = 1'b0;
    bp_enable <= 1'b1;
    for (int k = 0; k < 24; k++) begin
        m = rand_msg();
        expect_out(m, ref_route(m.tgt, present));
        send_one(m, k % 4);
    end
    wait_drain();
    bp_enable <= 1'b0;
    check_ordered();
    checks++;
    if (!stall_seen) begin
        errors++;
        $display("Inbound ready never dropped while the outbound ports were stalled");
    end
endtask

task automatic test_concurrent();
    nx_msg_t [3:0] msgs;
    for (int r = 0; r < 4; r++) begin
        for (int p = 0; p < 4; p++) begin
            msgs[p] = rand_msg();
            expect_out(msgs[p], ref_route(msgs[p].tgt, present));
        end
        send_batch(msgs, 4'hF);
    end
    wait_drain();
    check_unordered();
    check_val("o_idle", 64'(1'b1), 64'(idle_out));
endtask

// ================================================
// Main sequence
// ================================================

initial begin
    seed       = SEED;
    stall_seed = SEED;
    checks     = 0;
    errors     = 0;
    stall_left = 0;
    bp_enable  = 1'b0;
    stall_seen = 1'b0;
    rst_n      = 1'b0;
    idle_in    = 1'b1;
    in_data    = '0;
    in_valid   = 4'd0;
    present    = 4'hF;
    repeat (RESET_CYCLES) @(negedge clk);
    rst_n = 1'b1;

    test_reset();
    test_bypass();
    test_write_read();
    test_absent();
    test_backpressure();
    test_concurrent();

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
        $display("** PASS **");
    end else begin
        $display("** FAIL **");
    end
    $finish;
end

endmodule : nx_node_tb

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
# Compile the mesh node testbench with Verilator and run it
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module nx_node_tb -f build.f -Mdir obj_dir -o nx_node_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator compile failed with status $status"
    exit 1
fi

output=$(./obj_dir/nx_node_sim)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -Fqx '** PASS **'; then
    exit 0
else
    exit 1
fi

// ==== src/nx_node.sv ====
// Mesh node top level: data RAM, decoder, responder, combiner, distributor, idle
`timescale 1ns/1ps
`default_nettype none

module nx_node #(
    parameter int RAM_ADDR_W = 8
) (
      input  logic                  i_clk
    , input  logic                  i_rst_n
    // Control
    , input  nx_pkg::node_id_t      i_node_id
    , input  logic                  i_idle
    , output logic                  o_idle
    // Inbound interfaces
    , input  nx_pkg::nx_msg_t [3:0] i_inbound_data
    , input  logic [3:0]            i_inbound_valid
    , output logic [3:0]            o_inbound_ready
    // Outbound interfaces
    , output nx_pkg::nx_msg_t [3:0] o_outbound_data
    , output logic [3:0]            o_outbound_valid
    , input  logic [3:0]            i_outbound_ready
    , input  logic [3:0]            i_outbound_present
);

import nx_pkg::*;

// ================================================
// Signals
// ================================================

// RAM ports
logic  wr_en;
addr_t wr_addr;
data_t wr_data;
logic  rd_en;
addr_t rd_addr;
data_t rd_data;

// Decoder to responder
nx_msg_t req_data;
logic    req_valid;
logic    req_ready;

// Combiner, stream 0 bypass and stream 1 responses
nx_msg_t [1:0] comb_data;
logic [1:0]    comb_valid;
logic [1:0]    comb_ready;

// Combiner to distributor
nx_msg_t outbound_data;
logic    outbound_valid;
logic    outbound_ready;

// Block idles
logic decd_idle;
logic resp_idle;
logic comb_idle;
logic dist_idle;

// ================================================
// Data RAM
// ================================================

nx_ram #(
    .RAM_ADDR_W ( RAM_ADDR_W )
) u_data_ram (
      .i_clk     ( i_clk   )
    , .i_wr_en   ( wr_en   )
    , .i_wr_addr ( wr_addr )
    , .i_wr_data ( wr_data )
    , .i_rd_en   ( rd_en   )
    , .i_rd_addr ( rd_addr )
    , .o_rd_data ( rd_data )
);

// ================================================
// Messaging
// ================================================

nx_node_decoder u_decoder (
      .i_clk           ( i_clk           )
    , .i_rst_n         ( i_rst_n         )
    , .i_node_id       ( i_node_id       )
    , .o_idle          ( decd_idle       )
    , .i_inbound_data  ( i_inbound_data  )
    , .i_inbound_valid ( i_inbound_valid )
    , .o_inbound_ready ( o_inbound_ready )
    , .o_bypass_data   ( comb_data[0]    )
    , .o_bypass_valid  ( comb_valid[0]   )
    , .i_bypass_ready  ( comb_ready[0]   )
    , .o_req_data      ( req_data        )
    , .o_req_valid     ( req_valid       )
    , .i_req_ready     ( req_ready       )
    , .o_wr_en         ( wr_en           )
    , .o_wr_addr       ( wr_addr         )
    , .o_wr_data       ( wr_data         )
);

// Takes the place of the execution core as the second source
nx_node_responder u_responder (
      .i_clk       ( i_clk         )
    , .i_rst_n     ( i_rst_n       )
    , .i_node_id   ( i_node_id     )
    , .o_idle      ( resp_idle     )
    , .i_req_data  ( req_data      )
    , .i_req_valid ( req_valid     )
    , .o_req_ready ( req_ready     )
    , .o_rd_en     ( rd_en         )
    , .o_rd_addr   ( rd_addr       )
    , .i_rd_data   ( rd_data       )
    , .o_rsp_data  ( comb_data[1]  )
    , .o_rsp_valid ( comb_valid[1] )
    , .i_rsp_ready ( comb_ready[1] )
);

nx_stream_arbiter #(
    .STREAMS ( 2 )
) u_combiner (
      .i_clk            ( i_clk          )
    , .i_rst_n          ( i_rst_n        )
    , .o_idle           ( comb_idle      )
    , .i_inbound_data   ( comb_data      )
    , .i_inbound_valid  ( comb_valid     )
    , .o_inbound_ready  ( comb_ready     )
    , .o_outbound_data  ( outbound_data  )
    , .o_outbound_valid ( outbound_valid )
    , .i_outbound_ready ( outbound_ready )
);

nx_node_distributor u_distributor (
      .i_clk              ( i_clk              )
    , .i_rst_n            ( i_rst_n            )
    , .i_node_id          ( i_node_id          )
    , .o_idle             ( dist_idle          )
    , .i_outbound_data    ( outbound_data      )
    , .i_outbound_valid   ( outbound_valid     )
    , .o_outbound_ready   ( outbound_ready     )
    , .o_external_data    ( o_outbound_data    )
    , .o_external_valid   ( o_outbound_valid   )
    , .i_external_ready   ( i_outbound_ready   )
    , .i_external_present ( i_outbound_present )
);

// ================================================
// Idle chain
// ================================================

// Idle only when upstream and every block here are empty
assign o_idle = &{i_idle, decd_idle, resp_idle, comb_idle, dist_idle};

endmodule : nx_node

`default_nettype wire

// ==== src/nx_node_decoder.sv ====
// Inbound decoder: port selection, local command decode, RAM write and bypass
`timescale 1ns/1ps
`default_nettype none

module nx_node_decoder (
      input  logic                  i_clk
    , input  logic                  i_rst_n
    // Control
    , input  nx_pkg::node_id_t      i_node_id
    , output logic                  o_idle
    // Inbound interfaces
    , input  nx_pkg::nx_msg_t [3:0] i_inbound_data
    , input  logic [3:0]            i_inbound_valid
    , output logic [3:0]            o_inbound_ready
    // Forwarded traffic
    , output nx_pkg::nx_msg_t       o_bypass_data
    , output logic                  o_bypass_valid
    , input  logic                  i_bypass_ready
    // Read requests to the responder
    , output nx_pkg::nx_msg_t       o_req_data
    , output logic                  o_req_valid
    , input  logic                  i_req_ready
    // RAM port A
    , output logic                  o_wr_en
    , output nx_pkg::addr_t         o_wr_addr
    , output nx_pkg::data_t         o_wr_data
);

import nx_pkg::*;

// ================================================
// Signals
// ================================================

// One-entry hold register
nx_msg_t hold_msg;
logic    hold_valid;

// Inbound selection
nx_msg_t sel_msg;
logic    seen;
logic    take;
logic    can_accept;

// Decode of the held message
logic is_local;
logic is_read;
logic drain;

// ================================================
// Inbound selection
// ================================================

// Lowest numbered valid port wins, higher ports see ready low
always_comb begin
    seen    = 1'b0;
    sel_msg = i_inbound_data[0];
    for (int i = 0; i < 4; i++) begin
        o_inbound_ready[i] = can_accept && !seen;
        if (i_inbound_valid[i] && !seen) begin
            sel_msg = i_inbound_data[i];
        end
        seen = seen || i_inbound_valid[i];
    end
end

assign take = can_accept && (|i_inbound_valid);

// ================================================
// Decode
// ================================================

assign is_local = (hold_msg.tgt == i_node_id);
assign is_read  = (hold_msg.cmd == CMD_READ);

// Local WRITE and RESPONSE leave at once, READ waits on the responder
assign drain = hold_valid && (is_local ? (!is_read || i_req_ready) : i_bypass_ready);

// Empty, or emptying on this edge
assign can_accept = !hold_valid || drain;

// Write commits on the edge after capture
assign o_wr_en   = hold_valid && is_local && (hold_msg.cmd == CMD_WRITE);
assign o_wr_addr = hold_msg.addr;
assign o_wr_data = hold_msg.data;

assign o_req_data  = hold_msg;
assign o_req_valid = hold_valid && is_local && is_read;

// Anything for another node
assign o_bypass_data  = hold_msg;
assign o_bypass_valid = hold_valid && !is_local;

assign o_idle = !hold_valid;

// ================================================
// Hold register
// ================================================

always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
        hold_valid <= 1'b0;
    end else if (take) begin
        hold_valid <= 1'b1;
    end else if (drain) begin
        hold_valid <= 1'b0;
    end
end

// Payload
always_ff @(posedge i_clk) begin
    if (take) begin
        hold_msg <= sel_msg;
    end
end

endmodule : nx_node_decoder

`default_nettype wire

// ==== src/nx_node_distributor.sv ====
// Outbound distributor: dimension-ordered route and registered drive of one port
`timescale 1ns/1ps
`default_nettype none

module nx_node_distributor (
      input  logic                  i_clk
    , input  logic                  i_rst_n
    // Control
    , input  nx_pkg::node_id_t      i_node_id
    , output logic                  o_idle
    // Message to send
    , input  nx_pkg::nx_msg_t       i_outbound_data
    , input  logic                  i_outbound_valid
    , output logic                  o_outbound_ready
    // Cardinal ports
    , output nx_pkg::nx_msg_t [3:0] o_external_data
    , output logic [3:0]            o_external_valid
    , input  logic [3:0]            i_external_ready
    , input  logic [3:0]            i_external_present
);

import nx_pkg::*;

// ================================================
// Route
// ================================================

// Column first, then row, then clockwise past absent neighbours
function automatic logic [1:0] route(
    input node_id_t   tgt,
    input node_id_t   own,
    input logic [3:0] present
);
    logic [1:0] pref;
    logic [1:0] cand;
    logic [1:0] dir;
    logic       found;
    if (tgt.col > own.col) begin
        pref = DIR_EAST;
    end else if (tgt.col < own.col) begin
        pref = DIR_WEST;
    end else if (tgt.row > own.row) begin
        pref = DIR_SOUTH;
    end else begin
        pref = DIR_NORTH;
    end
    dir   = pref;
    found = 1'b0;
    for (int k = 0; k < 4; k++) begin
        cand = pref + 2'(k);
        if (!found && present[cand]) begin
            dir   = cand;
            found = 1'b1;
        end
    end
    return dir;
endfunction

// ================================================
// Output register
// ================================================

nx_msg_t    msg_q;
logic [3:0] valid_q;
logic [1:0] dir;
logic       take;

assign dir = route(i_outbound_data.tgt, i_node_id, i_external_present);

// Free when empty or when the selected port takes its message
assign o_outbound_ready = !(|valid_q) || (|(valid_q & i_external_ready));
assign take             = i_outbound_valid && o_outbound_ready;

always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
        valid_q <= 4'd0;
    end else if (o_outbound_ready) begin
        valid_q <= take ? (4'd1 << dir) : 4'd0;
    end
end

always_ff @(posedge i_clk) begin
    if (take) begin
        msg_q <= i_outbound_data;
    end
end

// Same payload on every port, only one valid
assign o_external_data  = {4{msg_q}};
assign o_external_valid = valid_q;
assign o_idle           = !(|valid_q);

endmodule : nx_node_distributor

`default_nettype wire

// ==== src/nx_node_responder.sv ====
// Read responder: accepts READ requests, reads the RAM and returns a RESPONSE
`timescale 1ns/1ps
`default_nettype none

module nx_node_responder (
      input  logic             i_clk
    , input  logic             i_rst_n
    // Control
    , input  nx_pkg::node_id_t i_node_id
    , output logic             o_idle
    // Requests from the decoder
    , input  nx_pkg::nx_msg_t  i_req_data
    , input  logic             i_req_valid
    , output logic             o_req_ready
    // RAM port B
    , output logic             o_rd_en
    , output nx_pkg::addr_t    o_rd_addr
    , input  nx_pkg::data_t    i_rd_data
    // Responses to the combiner
    , output nx_pkg::nx_msg_t  o_rsp_data
    , output logic             o_rsp_valid
    , input  logic             i_rsp_ready
);

import nx_pkg::*;

// ================================================
// Signals
// ================================================

// Request captured, RAM read still to come
logic     rd_pend;
// RESPONSE offered downstream
logic     rsp_valid;
// Request fields kept for the reply
node_id_t req_src;
addr_t    req_addr;
logic     req_take;

// One request in flight at a time
assign o_req_ready = !rd_pend && !rsp_valid;
assign req_take    = i_req_valid && o_req_ready;

// RAM read on the edge after the request
assign o_rd_en   = rd_pend;
assign o_rd_addr = req_addr;

// ================================================
// Control
// ================================================

always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
        rd_pend   <= 1'b0;
        rsp_valid <= 1'b0;
    end else begin
        rd_pend <= req_take;
        if (rd_pend) begin
            rsp_valid <= 1'b1;
        end else if (i_rsp_ready) begin
            rsp_valid <= 1'b0;
        end
    end
end

always_ff @(posedge i_clk) begin
    if (req_take) begin
        req_src  <= i_req_data.src;
        req_addr <= i_req_data.addr;
    end
end

// ================================================
// RESPONSE
// ================================================

// RAM output stays put, port B is idle until the next request
always_comb begin
    o_rsp_data      = '0;
    o_rsp_data.tgt  = req_src;
    o_rsp_data.src  = i_node_id;
    o_rsp_data.cmd  = CMD_RESPONSE;
    o_rsp_data.addr = req_addr;
    o_rsp_data.data = i_rd_data;
end

assign o_rsp_valid = rsp_valid;
assign o_idle      = !rd_pend && !rsp_valid;

endmodule : nx_node_responder

`default_nettype wire

// ==== src/nx_pkg.sv ====
// Shared widths, node identity, message struct, command codes and port directions
`default_nettype none

package nx_pkg;

// ================================================
// Field widths
// ================================================

// One row or column position in the mesh
typedef logic [3:0]  coord_t;
// Data RAM word address
typedef logic [7:0]  addr_t;
// RAM word, also the message payload
typedef logic [31:0] data_t;
// Message command, a field rather than a state
typedef logic [1:0]  cmd_t;

// Node identity, row held above column
typedef struct packed {
    coord_t row;
    coord_t col;
} node_id_t;

// ================================================
// Commands
// ================================================

localparam cmd_t CMD_WRITE    = 2'd0;
localparam cmd_t CMD_READ     = 2'd1;
localparam cmd_t CMD_RESPONSE = 2'd2;

// Message carried by every stream, 58 bits in total
typedef struct packed {
    node_id_t tgt;
    node_id_t src;
    cmd_t     cmd;
    addr_t    addr;
    data_t    data;
} nx_msg_t;

// ================================================
// Port directions
// ================================================

// Rows grow southwards, columns grow eastwards
localparam logic [1:0] DIR_NORTH = 2'd0;
localparam logic [1:0] DIR_EAST  = 2'd1;
localparam logic [1:0] DIR_SOUTH = 2'd2;
localparam logic [1:0] DIR_WEST  = 2'd3;

endpackage : nx_pkg

`default_nettype wire

// ==== src/nx_ram.sv ====
// Dual-port data RAM, write-only port A and registered read port B
`timescale 1ns/1ps
`default_nettype none

module nx_ram #(
    parameter int RAM_ADDR_W = 8
) (
      input  logic          i_clk
    // Port A, write only
    , input  logic          i_wr_en
    , input  nx_pkg::addr_t i_wr_addr
    , input  nx_pkg::data_t i_wr_data
    // Port B, read only
    , input  logic          i_rd_en
    , input  nx_pkg::addr_t i_rd_addr
    , output nx_pkg::data_t o_rd_data
);

import nx_pkg::*;

localparam int DEPTH = 2 ** RAM_ADDR_W;

// Word storage
data_t mem [DEPTH];

// Low address bits only
logic [RAM_ADDR_W-1:0] wr_idx;
logic [RAM_ADDR_W-1:0] rd_idx;

assign wr_idx = i_wr_addr[RAM_ADDR_W-1:0];
assign rd_idx = i_rd_addr[RAM_ADDR_W-1:0];

// Synchronous write
always_ff @(posedge i_clk) begin
    if (i_wr_en) begin
        mem[wr_idx] <= i_wr_data;
    end
end

// Read data held until the next enabled read
always_ff @(posedge i_clk) begin
    if (i_rd_en) begin
        o_rd_data <= mem[rd_idx];
    end
end

endmodule : nx_ram

`default_nettype wire

// ==== src/nx_stream_arbiter.sv ====
// Fixed-priority combiner of several message streams into one registered stream
`timescale 1ns/1ps
`default_nettype none

module nx_stream_arbiter #(
    parameter int STREAMS = 2
) (
      input  logic                          i_clk
    , input  logic                          i_rst_n
    , output logic                          o_idle
    // Inbound streams, index 0 has priority
    , input  nx_pkg::nx_msg_t [STREAMS-1:0] i_inbound_data
    , input  logic [STREAMS-1:0]            i_inbound_valid
    , output logic [STREAMS-1:0]            o_inbound_ready
    // Merged stream
    , output nx_pkg::nx_msg_t               o_outbound_data
    , output logic                          o_outbound_valid
    , input  logic                          i_outbound_ready
);

import nx_pkg::*;

// Output register
nx_msg_t out_msg;
logic    out_valid;

// Grant
nx_msg_t sel_msg;
logic    seen;
logic    open;
logic    take;

// Register empty or draining this edge
assign open = !out_valid || i_outbound_ready;
assign take = open && (|i_inbound_valid);

// Lowest indexed valid stream takes the slot
always_comb begin
    seen    = 1'b0;
    sel_msg = i_inbound_data[0];
    for (int i = 0; i < STREAMS; i++) begin
        o_inbound_ready[i] = open && !seen;
        if (i_inbound_valid[i] && !seen) begin
            sel_msg = i_inbound_data[i];
        end
        seen = seen || i_inbound_valid[i];
    end
end

always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
        out_valid <= 1'b0;
    end else if (open) begin
        out_valid <= take;
    end
end

always_ff @(posedge i_clk) begin
    if (take) begin
        out_msg <= sel_msg;
    end
end

assign o_outbound_data  = out_msg;
assign o_outbound_valid = out_valid;
assign o_idle           = !out_valid;

endmodule : nx_stream_arbiter

`default_nettype wire
